/* Makefile */
TOP := tb_lambda_layer

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "sim passed"

obj_dir/V$(TOP): compile.f verilog/*.sv verification/*.sv
	verilator --binary --assert -Wno-fatal -f compile.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --assert --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* compile.f */
verilog/lambda_pkg.sv
verilog/pipe_ctrl.sv
verilog/softplus_pwl.sv
verilog/sqrt_pipe.sv
verilog/noise_lfsr.sv
verilog/mean_delay.sv
verilog/scale_shift.sv
verilog/lambda_layer.sv
verification/tb_lambda_layer.sv

/* verification/lambda_stim.txt */
// Columns: mean, var, expected lambda; Q8.8 hex
// Line k is the k-th output after reset
0100 0000 01ba  // slice 4 start
0280 fa00 0280  // lower tail, root 0
fe00 0800 0172  // upper tail
0000 fc00 0015  // exactly -4
0100 0400 019c  // exactly 4
0200 fd80 0175
ff00 fe40 fe9d
0040 ffc0 016e
0300 0180 0162
fc00 0240 fe1e
0000 03ff 0162  // root just below 513
0500 0033 054f
8100 7f00 8000  // saturates low
0010 fc80 ffe6
7e00 2000 7fff  // saturates high
0100 ff00 0050
ff80 0100 fecb
7f00 0200 7fff
8080 fe00 8017  // near the floor, no clamp
0400 0300 02fe

/* verification/tb_lambda_layer.sv */
//****************************************
// Testbench for lambda_layer: reset,
// latency, streaming, saturation, stalls
//****************************************

module tb_lambda_layer import lambda_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_VEC = 20;    // Vectors in the stim file
    localparam int TIMEOUT = 200;   // Cycles per wait loop
    localparam int RST_CYC = 16;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic        in_ready;
    lambda_in_t  in_data;
    logic        out_valid;
    logic        out_ready;
    lambda_out_t out_data;

    logic [15:0] stim_mem [3*NUM_VEC];  // mean, var, expected per vector
    fix_t        exp_q [$];             // Expected lambda in send order
    int          seed = 32'h3562;
    int          cycle = 0;
    int          err_cnt = 0;
    int          chk_cnt = 0;
    int          out_cnt;               // Outputs since last reset
    int          sat_cnt;               // Matched saturated outputs
    int          sat_seen;              // sat_cnt kept from the clean stream
    int          stall_cnt;             // Cycles with a held output
    int          acc_cyc;               // Cycle of the latest input handshake
    int          last_out_cyc;
    bit          aborted = 1'b0;        // Any timeout ends the test list
    bit          held = 1'b0;
    fix_t        held_data;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;          // 4 ns period
    end

    always @(posedge clk) cycle <= cycle + 1;

    lambda_layer i_lambda_layer (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    // Pop one expected value per delivered output
    task automatic check_output();
        fix_t exp;
        chk_cnt++;
        if (exp_q.size() == 0) begin
            $display("Output delivered with no input outstanding");
            err_cnt++;
        end else begin
            exp = exp_q.pop_front();
            assert (out_data.lambda == exp) else begin
                $display("Fail out_data.lambda: expected 0x%h, got 0x%h", exp, out_data.lambda);
                err_cnt++;
            end
            if (out_data.lambda == exp && (exp == FIX_MAX || exp == FIX_MIN))
                sat_cnt++;
        end
        out_cnt++;
        last_out_cyc = cycle;
    endtask

    // Sampled mid-cycle, away from both edges
    always @(negedge clk) begin
        if (rst) begin
            held = 1'b0;
        end else begin
            if (held) begin           // Stalled last cycle, must not move
                chk_cnt++;
                assert (out_valid && out_data.lambda == held_data) else begin
                    $display("Fail out_data while stalled: expected 0x%h, got 0x%h",
                             held_data, out_data.lambda);
                    err_cnt++;
                end
            end
            if (out_valid && out_ready)
                check_output();
            held      = out_valid && !out_ready;
            held_data = out_data.lambda;
            if (held)
                stall_cnt++;
        end
    end

    task automatic check_idle();
        chk_cnt++;
        assert (!out_valid && in_ready) else begin
            $display("Fail out_valid/in_ready: expected 0x0/0x1, got 0x%h/0x%h",
                     out_valid, in_ready);
            err_cnt++;
        end
    endtask

    // Reset with the sink idle, so in_ready comes only from the empty last slot
    task automatic reset_dut();
        rst       = 1'b1;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        in_data   = '0;
        repeat (RST_CYC) begin
            @(posedge clk);
            #1;
            check_idle();
        end
        rst = 1'b0;
        exp_q.delete();
        out_cnt   = 0;
        sat_cnt   = 0;
        stall_cnt = 0;
        @(posedge clk);
        #1;
        check_idle();                 // First cycle out of reset
    endtask

    // Send vectors 0..count-1, then drain; gaps draws idle cycles and stalls
    task automatic stream_vectors(input int count, input bit gaps);
        int sent;
        int idle;                     // Cycles without any handshake
        int seen;
        bit took;
        sent = 0;
        idle = 0;
        seen = out_cnt;
        while ((sent < count || exp_q.size() > 0) && idle < TIMEOUT) begin
            if (!in_valid && sent < count && (!gaps || (($random(seed) & 3) != 0))) begin
                in_valid         = 1'b1;
                in_data.mean     = fix_t'(stim_mem[3*sent]);
                in_data.variance = fix_t'(stim_mem[3*sent+1]);
            end
            out_ready = gaps ? (($random(seed) & 1) != 0) : 1'b1;
            @(negedge clk);
            took = in_valid && in_ready;
            if (took)
                acc_cyc = cycle;
            @(posedge clk);
            #1;
            if (took) begin
                exp_q.push_back(fix_t'(stim_mem[3*sent+2]));
                sent++;
                in_valid = 1'b0;
            end
            idle = (took || out_cnt != seen) ? 0 : idle + 1;
            seen = out_cnt;
        end
        in_valid  = 1'b0;
        out_ready = 1'b1;
        if (idle >= TIMEOUT) begin
            $display("Timeout: pipeline made no progress for %0d cycles", TIMEOUT);
            err_cnt++;
            aborted = 1'b1;
        end
    endtask

    // Idle a little longer to catch duplicates, then count
    task automatic check_count(input int count);
        repeat (PIPE_LAT + 2) @(posedge clk);
        #1;
        chk_cnt++;
        assert (out_cnt == count) else begin
            $display("Fail out_cnt: expected 0x%h, got 0x%h", count, out_cnt);
            err_cnt++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int base);
        if (err_cnt == base)
            $display("test %0d %s: ok", num, name);
        else
            $display("test %0d %s: %0d errors", num, name, err_cnt - base);
    endtask

    function automatic int sat_lines();
        int n;
        n = 0;
        for (int i = 0; i < NUM_VEC; i++) begin
            if (fix_t'(stim_mem[3*i+2]) == FIX_MAX || fix_t'(stim_mem[3*i+2]) == FIX_MIN)
                n++;
        end
        return n;
    endfunction

    task automatic run_stream(input int num, input string name, input bit gaps);
        int base;
        base = err_cnt;
        if (aborted)
            return;
        reset_dut();
        stream_vectors(NUM_VEC, gaps);
        if (!aborted)
            check_count(NUM_VEC);
        if (gaps && stall_cnt == 0) begin
            $display("Back-pressure never stalled the output");
            err_cnt++;
        end
        report_test(num, name, base);
    endtask

    initial begin
        int base;
        $readmemh("verification/lambda_stim.txt", stim_mem);
        assert (!$isunknown(stim_mem[3*NUM_VEC-1])) else begin
            $display("Stimulus file is missing or shorter than %0d vectors", NUM_VEC);
            err_cnt++;
            aborted = 1'b1;
        end

        base = err_cnt;
        reset_dut();
        report_test(1, "reset state", base);

        base = err_cnt;
        if (!aborted) begin
            reset_dut();
            stream_vectors(1, 1'b0);  // Lone vector, sink always ready
            chk_cnt++;
            assert (aborted || last_out_cyc - acc_cyc == PIPE_LAT) else begin
                $display("Fail latency: expected 0x%h, got 0x%h",
                         PIPE_LAT, last_out_cyc - acc_cyc);
                err_cnt++;
            end
            report_test(2, "fixed latency", base);
        end

        run_stream(3, "streaming", 1'b0);
        sat_seen = sat_cnt;

        base = err_cnt;
        if (!aborted) begin
            chk_cnt++;
            assert (sat_lines() > 0 && sat_seen == sat_lines()) else begin
                $display("Fail sat_cnt: expected 0x%h, got 0x%h", sat_lines(), sat_seen);
                err_cnt++;
            end
            report_test(4, "saturation", base);
        end

        run_stream(5, "back-pressure", 1'b1);

        $display("%0d checks, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

/* verilog/lambda_layer.sv */
//****************************************
// Sampling layer top level that forms
// mean + sigma * eps
//****************************************

module lambda_layer import lambda_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    output logic        in_ready,
    input  lambda_in_t  in_data,
    output logic        out_valid,
    input  logic        out_ready,
    output lambda_out_t out_data
);

    logic  adv;         // Shared advance for every stage
    logic  noise_step;  // One LFSR step per multiplied item
    ufix_t sp_val;      // softplus(var)
    ufix_t root;        // sqrt(softplus(var))
    fix_t  eps;         // Current noise sample
    fix_t  mean_dly;    // Mean aligned to add stage

    // Valid tracking and stall control
    pipe_ctrl i_pipe_ctrl (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .out_ready  (out_ready),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .adv        (adv),
        .noise_step (noise_step)
    );

    softplus_pwl i_softplus_pwl (
        .clk    (clk),
        .rst    (rst),
        .adv    (adv),
        .var_in (in_data.variance),
        .sp_out (sp_val)
    );

    sqrt_pipe i_sqrt_pipe (
        .clk      (clk),
        .rst      (rst),
        .adv      (adv),
        .rad_in   (sp_val),
        .root_out (root)
    );

    noise_lfsr i_noise_lfsr (
        .clk        (clk),
        .rst        (rst),
        .noise_step (noise_step),
        .eps        (eps)
    );

    // Mean held back until the add stage
    mean_delay #(.DEPTH(MEAN_DELAY)) i_mean_delay (
        .clk      (clk),
        .rst      (rst),
        .adv      (adv),
        .mean_in  (in_data.mean),
        .mean_out (mean_dly)
    );

    scale_shift i_scale_shift (
        .clk    (clk),
        .rst    (rst),
        .adv    (adv),
        .root   (root),
        .eps    (eps),
        .mean   (mean_dly),
        .lambda (out_data.lambda)
    );

endmodule

/* verilog/lambda_pkg.sv */
//****************************************
// Shared Q8.8 types, pipeline depths,
// noise constants and softplus slices
//****************************************

package lambda_pkg;

    // Q8.8 words
    typedef logic signed [15:0] fix_t;      // Signed datapath value
    typedef logic        [15:0] ufix_t;     // Softplus result and root

    // Pair presented at the input port
    typedef struct packed {
        fix_t mean;      // Upper word
        fix_t variance;  // Raw variance, lower word
    } lambda_in_t;

    typedef struct packed {
        fix_t lambda;    // Sampled latent value
    } lambda_out_t;

    // Stage latencies in cycles
    localparam int SOFTPLUS_LAT = 2;
    localparam int SQRT_LAT     = 6;
    localparam int SCALE_LAT    = 2;
    localparam int PIPE_LAT     = SOFTPLUS_LAT + SQRT_LAT + SCALE_LAT;  // 10
    localparam int MEAN_DELAY   = PIPE_LAT - 1;              // Mean joins at add stage
    localparam int NOISE_STAGE  = SOFTPLUS_LAT + SQRT_LAT;   // Slot feeding multiply

    // Noise source
    localparam logic [15:0] LFSR_SEED = 16'hACE1;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;  // Galois, right shift
    localparam int          EPS_BITS  = 10;         // Low bits kept, about +-2

    // Softplus slice table, one unit slice each over [-4, 4)
    localparam fix_t SP_LO = -16'sd1024;  // -4.0, zero below
    localparam fix_t SP_HI = 16'sd1024;   // 4.0, identity at and above
    localparam ufix_t SP_SLOPE [8] = '{
        16'd7,   16'd20,  16'd48,  16'd97,   // Slices -4 .. -1
        16'd159, 16'd208, 16'd236, 16'd249   // Slices 0 .. 3
    };
    localparam ufix_t SP_ICPT [8] = '{
        16'd5,   16'd12,  16'd32,  16'd80,   // softplus at slice start
        16'd177, 16'd336, 16'd544, 16'd780
    };

    // Square root sizing
    localparam int SQRT_BITS  = 12;              // Result bits, two per stage
    localparam int SQRT_RAD_W = 2 * SQRT_BITS;   // Radicand after << 8
    localparam int SQRT_REM_W = SQRT_BITS + 3;   // Signed partial remainder

    // Multiply width after dropping 8 fraction bits
    localparam int SCALE_PROD_W = 25;

    // Saturation limits
    localparam fix_t FIX_MAX = 16'sh7FFF;
    localparam fix_t FIX_MIN = 16'sh8000;

endpackage

/* verilog/mean_delay.sv */
//****************************************
// Enable-gated delay line for the mean
//****************************************

module mean_delay import lambda_pkg::*; #(
    parameter int DEPTH = MEAN_DELAY   // Cycles of adv before mean_out
) (
    input  logic clk,
    input  logic rst,
    input  logic adv,
    input  fix_t mean_in,
    output fix_t mean_out
);

    if (DEPTH == 0) begin : g_none
        assign mean_out = mean_in;  // Degenerate depth, no storage
    end else begin : g_line
        fix_t dly_q [DEPTH];

        always_ff @(posedge clk) begin
            if (rst) begin
                for (int i = 0; i < DEPTH; i++)
                    dly_q[i] <= '0;
            end else if (adv) begin  // Frozen with the rest of the pipe
                dly_q[0] <= mean_in;
                for (int i = 1; i < DEPTH; i++)
                    dly_q[i] <= dly_q[i-1];
            end
        end

        assign mean_out = dly_q[DEPTH-1];
    end

endmodule

/* verilog/noise_lfsr.sv */
//****************************************
// Galois LFSR noise, Q8.8 sample output
//****************************************

module noise_lfsr import lambda_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic noise_step,
    output fix_t eps
);

    logic [15:0] state_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= LFSR_SEED;
        end else if (noise_step) begin
            // Shift right, fold taps in when a one drops out
            state_q <= {1'b0, state_q[15:1]} ^ (state_q[0] ? LFSR_TAPS : 16'h0000);
        end
    end

    // Low bits as signed fraction, uniform in about [-2, 2)
    assign eps = {{(16-EPS_BITS){state_q[EPS_BITS-1]}}, state_q[EPS_BITS-1:0]};

    // All-zero state would lock the generator
    a_state_live : assert property (
        @(posedge clk) disable iff (rst)
        state_q != '0
    );

endmodule

/* verilog/pipe_ctrl.sv */
//****************************************
// Stall controller with valid chain,
// shared advance, input ready and noise strobe
//****************************************

module pipe_ctrl import lambda_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  logic out_ready,
    output logic in_ready,
    output logic out_valid,
    output logic adv,
    output logic noise_step
);

    // Slot n is valid after n registers and slot PIPE_LAT is the output
    logic [PIPE_LAT:1] vld_q;

    // Whole pipe moves when the output drains or holds a bubble
    assign adv = out_ready | ~vld_q[PIPE_LAT];

    assign in_ready  = adv;             // Accept only when everything moves
    assign out_valid = vld_q[PIPE_LAT];

    // Step the LFSR as the item at the multiply input moves on
    assign noise_step = adv & vld_q[NOISE_STAGE];

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
        end else if (adv) begin
            vld_q <= {vld_q[PIPE_LAT-1:1], in_valid};  // Bubbles shift along too
        end
    end

    // A presented output stays until taken
    a_out_hold : assert property (
        @(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> out_valid
    );

endmodule

/* verilog/scale_shift.sv */
//****************************************
// Scale root by noise, add mean,
// saturate to Q8.8 range
//****************************************

module scale_shift import lambda_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  adv,
    input  ufix_t root,
    input  fix_t  eps,
    input  fix_t  mean,
    output fix_t  lambda
);

    logic signed [SCALE_PROD_W+7:0] prod_full;  // Q16.16 product
    logic signed [SCALE_PROD_W-1:0] prod_q;     // Back to 8 fraction bits
    logic signed [SCALE_PROD_W:0]   sum;        // One guard bit for the add

    // Root is unsigned, widen with a zero before the signed multiply
    assign prod_full = $signed({1'b0, root}) * eps;

    // Stage 1: product, arithmetic shift floors toward minus infinity
    always_ff @(posedge clk) begin
        if (rst)
            prod_q <= '0;
        else if (adv)
            prod_q <= prod_full[SCALE_PROD_W+7:8];
    end

    assign sum = prod_q + mean;  // Both sign extended

    // Stage 2: clamp into 16 bits
    always_ff @(posedge clk) begin
        if (rst) begin
            lambda <= '0;
        end else if (adv) begin
            if (sum > FIX_MAX)
                lambda <= FIX_MAX;
            else if (sum < FIX_MIN)
                lambda <= FIX_MIN;
            else
                lambda <= sum[15:0];
        end
    end

endmodule

/* verilog/softplus_pwl.sv */
//****************************************
// Piecewise-linear softplus, 8 slices,
// two register stages, clamped tails
//****************************************

module softplus_pwl import lambda_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  adv,
    input  fix_t  var_in,
    output ufix_t sp_out
);

    // Stage 1 regs
    logic [2:0] idx_q;    // Slice select
    logic [7:0] frac_q;   // Position inside slice
    logic       lo_q;     // Below -4, result 0
    logic       hi_q;     // At or above 4, pass through
    fix_t       pass_q;   // Input kept for upper tail

    ufix_t      slope;
    ufix_t      icpt;
    logic [23:0] ramp;    // slope * frac, Q8.16

    always_ff @(posedge clk) begin
        if (rst) begin
            idx_q  <= '0;
            frac_q <= '0;
            lo_q   <= 1'b0;
            hi_q   <= 1'b0;
            pass_q <= '0;
        end else if (adv) begin
            idx_q  <= var_in[10:8] + 3'd4;  // Integer part -4 maps to slice 0
            frac_q <= var_in[7:0];          // Floor fraction, also for negatives
            lo_q   <= var_in < SP_LO;
            hi_q   <= var_in >= SP_HI;
            pass_q <= var_in;
        end
    end

    // Table lookup on registered index
    assign slope = SP_SLOPE[idx_q];
    assign icpt  = SP_ICPT[idx_q];
    assign ramp  = slope * frac_q;

    // Stage 2: linear segment or tail
    always_ff @(posedge clk) begin
        if (rst) begin
            sp_out <= '0;
        end else if (adv) begin
            if (hi_q)
                sp_out <= ufix_t'(pass_q);   // softplus(x) ~ x for large x
            else if (lo_q)
                sp_out <= '0;                // Lower tail flushed
            else
                sp_out <= icpt + ramp[23:8]; // Truncate back to Q8.8
        end
    end

    // Result feeds sqrt as unsigned, sign bit must stay clear
    a_sp_nonneg : assert property (
        @(posedge clk) disable iff (rst)
        !sp_out[15]
    );

endmodule

/* verilog/sqrt_pipe.sv */
//****************************************
// Pipelined non-restoring square root,
// Q8.8 in and out, two root bits/stage
//****************************************

module sqrt_pipe import lambda_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  adv,
    input  ufix_t rad_in,
    output ufix_t root_out
);

    // State carried between stages
    typedef struct packed {
        logic signed [SQRT_REM_W-1:0] rem;   // Partial remainder, may go negative
        logic [SQRT_BITS-1:0]         root;  // Root bits found so far
        logic [SQRT_RAD_W-1:0]        rad;   // Radicand, rad_in << 8
    } sq_state_t;

    sq_state_t pipe_q [SQRT_LAT];

    // One non-restoring iteration, consumes one bit pair
    function automatic sq_state_t nr_step(input sq_state_t s, input logic [1:0] pair);
        sq_state_t n;
        n = s;
        if (!s.rem[SQRT_REM_W-1])  // Remainder positive, subtract 4Q+1
            n.rem = {s.rem[SQRT_REM_W-3:0], pair} - {1'b0, s.root, 2'b01};
        else                       // Negative, add 4Q+3 instead of restoring
            n.rem = {s.rem[SQRT_REM_W-3:0], pair} + {1'b0, s.root, 2'b11};
        n.root = {s.root[SQRT_BITS-2:0], ~n.rem[SQRT_REM_W-1]};  // New bit = sign
        return n;
    endfunction

    for (genvar s = 0; s < SQRT_LAT; s++) begin : g_stage
        sq_state_t stage_in;
        sq_state_t half;   // After first of two iterations

        if (s == 0) begin : g_first
            // Shift by 8 keeps the root in Q8.8
            assign stage_in = '{rem: '0, root: '0, rad: {rad_in, 8'h00}};
        end else begin : g_next
            assign stage_in = pipe_q[s-1];
        end

        // Stage s handles bit pairs 11-2s and 10-2s
        assign half = nr_step(stage_in, stage_in.rad[SQRT_RAD_W-2-4*s +: 2]);

        always_ff @(posedge clk) begin
            if (rst)
                pipe_q[s] <= '0;
            else if (adv)
                pipe_q[s] <= nr_step(half, half.rad[SQRT_RAD_W-4-4*s +: 2]);
        end
    end

    // 12-bit root zero extended
    assign root_out = ufix_t'(pipe_q[SQRT_LAT-1].root);

    // Floor property checked against the radicand that travelled with it
    a_root_floor : assert property (
        @(posedge clk) disable iff (rst)
        ({{SQRT_BITS{1'b0}}, pipe_q[SQRT_LAT-1].root}
            * {{SQRT_BITS{1'b0}}, pipe_q[SQRT_LAT-1].root})
            <= pipe_q[SQRT_LAT-1].rad
    );

endmodule
